/* mm_bus_pkg.sv */
/*
 * Bus-level definitions shared by the RAM wrapper and its testbench.
 * Holds the port widths, the read-data select encoding and the timer
 * interrupt id. Refer to items as mm_bus_pkg::name.
 */

package mm_bus_pkg;

    localparam int unsigned ADDR_WIDTH     = 32;
    localparam int unsigned DATA_WIDTH     = 32;
    localparam int unsigned BE_WIDTH       = 4;
    // low byte-address bits kept for the 4 KiB RAM
    localparam int unsigned RAM_ADDR_WIDTH = 12;

    localparam int unsigned IRQ_ID_WIDTH   = 5;
    localparam logic [IRQ_ID_WIDTH-1:0] TIMER_IRQ_ID = 5'd3;

    // where the response word of a port comes from in its rvalid cycle
    typedef enum logic [1:0] {
        SEL_IDLE,
        SEL_RAM,
        SEL_ZERO
    } rd_sel_e;

endpackage

/* mm_map_pkg.sv */
/*
 * Address map of the RAM wrapper.
 * Window bases and lengths for the RAM, stdout and timer, plus the
 * timer register offsets. Anything outside these windows is unmapped.
 */

package mm_map_pkg;

    // RAM is also mirrored at address 0 with the same length
    localparam logic [31:0] SRAM_BASE   = 32'h1C00_0000;
    localparam logic [31:0] SRAM_LEN    = 32'd1 << mm_bus_pkg::RAM_ADDR_WIDTH;

    // character output window
    localparam logic [31:0] STDOUT_BASE = 32'h1A10_F000;
    localparam logic [31:0] STDOUT_LEN  = 32'h0000_1000;

    // countdown timer window
    localparam logic [31:0] TIMER_BASE  = 32'h1510_0000;
    localparam logic [31:0] TIMER_LEN   = 32'h0000_1000;

    // byte offsets inside the timer window
    localparam logic [31:0] TIMER_MASK_OFS = 32'h0000_0000;
    localparam logic [31:0] TIMER_CNT_OFS  = 32'h0000_0004;

endpackage

/* mm_ram_if.sv */
/*
 * Data-side RAM port between the bus decoder and the dual-port RAM.
 * The decoder drives the request through ctrl, the RAM answers through
 * mem. rdata holds the word read at the last read edge.
 */

`timescale 1ns/1ps

interface mm_ram_if;

    logic                                  req;
    logic [mm_bus_pkg::RAM_ADDR_WIDTH-1:0] addr;
    logic                                  we;
    logic [mm_bus_pkg::BE_WIDTH-1:0]       be;
    logic [mm_bus_pkg::DATA_WIDTH-1:0]     wdata;
    logic [mm_bus_pkg::DATA_WIDTH-1:0]     rdata;

    modport ctrl (output req, addr, we, be, wdata, input rdata);

    modport mem (input req, addr, we, be, wdata, output rdata);

endinterface

/* mm_dp_ram.sv */
/*
 * Dual-port word RAM behind the bus decoder.
 * Port A is a read-only fetch port, port B the data port with byte
 * enables. Both read through a register, so data shows one cycle later.
 */

`timescale 1ns/1ps

module mm_dp_ram (
    input  logic                                  clk_i,

    input  logic                                  fetch_req_i,
    input  logic [mm_bus_pkg::RAM_ADDR_WIDTH-1:0] fetch_addr_i,
    output logic [mm_bus_pkg::DATA_WIDTH-1:0]     fetch_rdata_o,

    mm_ram_if.mem                                 data
);

    logic [mm_bus_pkg::DATA_WIDTH-1:0] mem_q [mm_map_pkg::SRAM_LEN / 4];

    // word index drops the byte offset bits
    logic [mm_bus_pkg::RAM_ADDR_WIDTH-3:0] fetch_widx;
    logic [mm_bus_pkg::RAM_ADDR_WIDTH-3:0] data_widx;

    assign fetch_widx = fetch_addr_i[mm_bus_pkg::RAM_ADDR_WIDTH-1:2];
    assign data_widx  = data.addr[mm_bus_pkg::RAM_ADDR_WIDTH-1:2];

    always_ff @(posedge clk_i) begin
        if (fetch_req_i) begin
            fetch_rdata_o <= mem_q[fetch_widx];
        end
    end

    always_ff @(posedge clk_i) begin
        if (data.req) begin
            if (data.we) begin
                for (int b = 0; b < mm_bus_pkg::BE_WIDTH; b++) begin
                    if (data.be[b]) begin
                        mem_q[data_widx][8*b +: 8] <= data.wdata[8*b +: 8];
                    end
                end
            end else begin
                data.rdata <= mem_q[data_widx];
            end
        end
    end

endmodule

/* mm_timer.sv */
/*
 * Countdown timer with its mask and count registers.
 * The decoder strobes writes in, the count runs down on every edge
 * without a register write, and reaching zero raises the interrupt if
 * the timer id is unmasked.
 */

`timescale 1ns/1ps

module mm_timer (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    input  logic                                tmr_we_i,
    input  logic                                tmr_sel_i,
    input  logic [mm_bus_pkg::DATA_WIDTH-1:0]   tmr_wdata_i,

    input  logic                                irq_ack_i,
    input  logic [mm_bus_pkg::IRQ_ID_WIDTH-1:0] irq_id_i,
    output logic                                irq_o
);

    logic [mm_bus_pkg::DATA_WIDTH-1:0] mask_q;
    logic [mm_bus_pkg::DATA_WIDTH-1:0] cnt_q;
    logic                              irq_q;
    logic                              irq_ack;

    assign irq_ack = irq_ack_i && (irq_id_i == mm_bus_pkg::TIMER_IRQ_ID);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= 1'b0;
        end else if (tmr_we_i) begin
            // a register write holds off counting for that edge
            if (tmr_sel_i) begin
                cnt_q <= tmr_wdata_i;
            end else begin
                mask_q <= tmr_wdata_i;
            end
        end else begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            // the step from 1 to 0 sets the flag and the ack below takes priority
            if (cnt_q == 1 && mask_q[mm_bus_pkg::TIMER_IRQ_ID]) begin
                irq_q <= 1'b1;
            end
            if (irq_ack) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign irq_o = irq_q;

endmodule

/* mm_bus_decode.sv */
/*
 * Address decoder and response logic for the fetch and data ports.
 * Grants every request in its own cycle, steers it to the RAM, the
 * stdout register or the timer strobe, and returns rvalid one cycle later
 * with the RAM word or zero.
 */

`timescale 1ns/1ps

module mm_bus_decode (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    input  logic                              instr_req_i,
    input  logic [mm_bus_pkg::ADDR_WIDTH-1:0] instr_addr_i,
    output logic                              instr_gnt_o,
    output logic                              instr_rvalid_o,
    output logic [mm_bus_pkg::DATA_WIDTH-1:0] instr_rdata_o,

    input  logic                              data_req_i,
    input  logic [mm_bus_pkg::ADDR_WIDTH-1:0] data_addr_i,
    input  logic                              data_we_i,
    input  logic [mm_bus_pkg::BE_WIDTH-1:0]   data_be_i,
    input  logic [mm_bus_pkg::DATA_WIDTH-1:0] data_wdata_i,
    output logic                              data_gnt_o,
    output logic                              data_rvalid_o,
    output logic [mm_bus_pkg::DATA_WIDTH-1:0] data_rdata_o,

    output logic                                  ram_fetch_req_o,
    output logic [mm_bus_pkg::RAM_ADDR_WIDTH-1:0] ram_fetch_addr_o,
    input  logic [mm_bus_pkg::DATA_WIDTH-1:0]     ram_fetch_rdata_i,
    mm_ram_if.ctrl                                ram,

    output logic                              stdout_valid_o,
    output logic [mm_bus_pkg::DATA_WIDTH-1:0] stdout_data_o,

    output logic                              tmr_we_o,
    output logic                              tmr_sel_o,
    output logic [mm_bus_pkg::DATA_WIDTH-1:0] tmr_wdata_o
);

    function automatic logic in_window(input logic [mm_bus_pkg::ADDR_WIDTH-1:0] addr,
                                       input logic [31:0] base,
                                       input logic [31:0] len);
        return (addr >= base) && (addr < base + len);
    endfunction

    // RAM answers at SRAM_BASE and again at 0
    function automatic logic in_sram(input logic [mm_bus_pkg::ADDR_WIDTH-1:0] addr);
        return in_window(addr, mm_map_pkg::SRAM_BASE, mm_map_pkg::SRAM_LEN) ||
               in_window(addr, 32'h0, mm_map_pkg::SRAM_LEN);
    endfunction

    logic                              instr_in_ram;
    logic                              data_in_ram;
    logic                              data_in_stdout;
    logic                              data_in_timer;
    logic [31:0]                       tmr_ofs;
    logic                              instr_rvalid_q;
    logic                              data_rvalid_q;
    logic                              stdout_valid_q;
    logic [mm_bus_pkg::DATA_WIDTH-1:0] stdout_data_q;
    mm_bus_pkg::rd_sel_e               instr_sel_d, instr_sel_q;
    mm_bus_pkg::rd_sel_e               data_sel_d, data_sel_q;

    assign instr_in_ram   = in_sram(instr_addr_i);
    assign data_in_ram    = in_sram(data_addr_i);
    assign data_in_stdout = in_window(data_addr_i, mm_map_pkg::STDOUT_BASE,
                                      mm_map_pkg::STDOUT_LEN);
    assign data_in_timer  = in_window(data_addr_i, mm_map_pkg::TIMER_BASE,
                                      mm_map_pkg::TIMER_LEN);
    assign tmr_ofs        = data_addr_i - mm_map_pkg::TIMER_BASE;

    // fetches have their own RAM port so nothing is ever held off
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    assign ram_fetch_req_o  = instr_req_i && instr_in_ram;
    // clipping the higher address bits gives the mirror
    assign ram_fetch_addr_o = instr_addr_i[mm_bus_pkg::RAM_ADDR_WIDTH-1:0];

    assign ram.req   = data_req_i && data_in_ram;
    assign ram.addr  = data_addr_i[mm_bus_pkg::RAM_ADDR_WIDTH-1:0];
    assign ram.we    = data_we_i;
    assign ram.be    = data_be_i;
    assign ram.wdata = data_wdata_i;

    // only the two real registers strobe the timer
    assign tmr_we_o    = data_req_i && data_we_i && data_in_timer &&
                         (tmr_ofs == mm_map_pkg::TIMER_MASK_OFS ||
                          tmr_ofs == mm_map_pkg::TIMER_CNT_OFS);
    assign tmr_sel_o   = (tmr_ofs == mm_map_pkg::TIMER_CNT_OFS);
    assign tmr_wdata_o = data_wdata_i;

    always_comb begin
        instr_sel_d = mm_bus_pkg::SEL_IDLE;
        data_sel_d  = mm_bus_pkg::SEL_IDLE;
        if (instr_req_i) begin
            instr_sel_d = instr_in_ram ? mm_bus_pkg::SEL_RAM : mm_bus_pkg::SEL_ZERO;
        end
        // writes and non-RAM reads answer with zero
        if (data_req_i) begin
            data_sel_d = (data_in_ram && !data_we_i) ? mm_bus_pkg::SEL_RAM
                                                     : mm_bus_pkg::SEL_ZERO;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
            stdout_valid_q <= 1'b0;
            instr_sel_q    <= mm_bus_pkg::SEL_IDLE;
            data_sel_q     <= mm_bus_pkg::SEL_IDLE;
        end else begin
            instr_rvalid_q <= instr_req_i;
            data_rvalid_q  <= data_req_i;
            stdout_valid_q <= data_req_i && data_we_i && data_in_stdout;
            instr_sel_q    <= instr_sel_d;
            data_sel_q     <= data_sel_d;
        end
    end

    // the character word is only meaningful while stdout_valid_o is high
    always_ff @(posedge clk_i) begin
        if (data_req_i && data_we_i && data_in_stdout) begin
            stdout_data_q <= data_wdata_i;
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;
    assign data_rvalid_o  = data_rvalid_q;
    assign stdout_valid_o = stdout_valid_q;
    assign stdout_data_o  = stdout_data_q;

    assign instr_rdata_o = (instr_sel_q == mm_bus_pkg::SEL_RAM) ? ram_fetch_rdata_i : '0;
    assign data_rdata_o  = (data_sel_q == mm_bus_pkg::SEL_RAM) ? ram.rdata : '0;

endmodule

/* mm_ram.sv */
/*
 * Memory-mapped RAM wrapper for the core test harness.
 * Fetch and data ports use the core's req/gnt/rvalid handshake. Behind
 * them sit a mirrored RAM, a stdout pulse output and a countdown timer.
 */

`timescale 1ns/1ps

module mm_ram (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    input  logic                                instr_req_i,
    input  logic [mm_bus_pkg::ADDR_WIDTH-1:0]   instr_addr_i,
    output logic                                instr_gnt_o,
    output logic                                instr_rvalid_o,
    output logic [mm_bus_pkg::DATA_WIDTH-1:0]   instr_rdata_o,

    input  logic                                data_req_i,
    input  logic [mm_bus_pkg::ADDR_WIDTH-1:0]   data_addr_i,
    input  logic                                data_we_i,
    input  logic [mm_bus_pkg::BE_WIDTH-1:0]     data_be_i,
    input  logic [mm_bus_pkg::DATA_WIDTH-1:0]   data_wdata_i,
    output logic                                data_gnt_o,
    output logic                                data_rvalid_o,
    output logic [mm_bus_pkg::DATA_WIDTH-1:0]   data_rdata_o,

    output logic                                stdout_valid_o,
    output logic [mm_bus_pkg::DATA_WIDTH-1:0]   stdout_data_o,

    input  logic                                irq_ack_i,
    input  logic [mm_bus_pkg::IRQ_ID_WIDTH-1:0] irq_id_i,
    output logic                                irq_o,
    output logic [mm_bus_pkg::IRQ_ID_WIDTH-1:0] irq_id_o
);

    logic                                  ram_fetch_req;
    logic [mm_bus_pkg::RAM_ADDR_WIDTH-1:0] ram_fetch_addr;
    logic [mm_bus_pkg::DATA_WIDTH-1:0]     ram_fetch_rdata;
    logic                                  tmr_we;
    logic                                  tmr_sel;
    logic [mm_bus_pkg::DATA_WIDTH-1:0]     tmr_wdata;

    mm_ram_if ram_bus ();

    mm_bus_decode i_decode (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .instr_req_i       (instr_req_i),
        .instr_addr_i      (instr_addr_i),
        .instr_gnt_o       (instr_gnt_o),
        .instr_rvalid_o    (instr_rvalid_o),
        .instr_rdata_o     (instr_rdata_o),
        .data_req_i        (data_req_i),
        .data_addr_i       (data_addr_i),
        .data_we_i         (data_we_i),
        .data_be_i         (data_be_i),
        .data_wdata_i      (data_wdata_i),
        .data_gnt_o        (data_gnt_o),
        .data_rvalid_o     (data_rvalid_o),
        .data_rdata_o      (data_rdata_o),
        .ram_fetch_req_o   (ram_fetch_req),
        .ram_fetch_addr_o  (ram_fetch_addr),
        .ram_fetch_rdata_i (ram_fetch_rdata),
        .ram               (ram_bus.ctrl),
        .stdout_valid_o    (stdout_valid_o),
        .stdout_data_o     (stdout_data_o),
        .tmr_we_o          (tmr_we),
        .tmr_sel_o         (tmr_sel),
        .tmr_wdata_o       (tmr_wdata)
    );

    mm_dp_ram i_ram (
        .clk_i         (clk_i),
        .fetch_req_i   (ram_fetch_req),
        .fetch_addr_i  (ram_fetch_addr),
        .fetch_rdata_o (ram_fetch_rdata),
        .data          (ram_bus.mem)
    );

    mm_timer i_timer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .tmr_we_i    (tmr_we),
        .tmr_sel_i   (tmr_sel),
        .tmr_wdata_i (tmr_wdata),
        .irq_ack_i   (irq_ack_i),
        .irq_id_i    (irq_id_i),
        .irq_o       (irq_o)
    );

    // timer is the only interrupt source
    assign irq_id_o = mm_bus_pkg::TIMER_IRQ_ID;

endmodule

/* tb_mm_checker.sv */
/*
 * Scoreboard for the RAM wrapper testbench.
 * Samples the DUT ports on every rising edge, keeps its own model of the
 * RAM bytes, the stdout pulse and the timer, and counts mismatches.
 */

`timescale 1ns/1ps

module tb_mm_checker (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        instr_req_i,
    input  logic [31:0] instr_addr_i,
    input  logic        instr_gnt_i,
    input  logic        instr_rvalid_i,
    input  logic [31:0] instr_rdata_i,
    input  logic        data_req_i,
    input  logic [31:0] data_addr_i,
    input  logic        data_we_i,
    input  logic [3:0]  data_be_i,
    input  logic [31:0] data_wdata_i,
    input  logic        data_gnt_i,
    input  logic        data_rvalid_i,
    input  logic [31:0] data_rdata_i,
    input  logic        stdout_valid_i,
    input  logic [31:0] stdout_data_i,
    input  logic        irq_ack_i,
    input  logic [4:0]  irq_id_i,
    input  logic        dut_irq_i,
    input  logic [4:0]  dut_irq_id_i,
    output int          value_errs_o,
    output int          proto_errs_o
);

    logic [7:0]  ram_model [4096];
    logic        instr_pend, data_pend, stdout_pend;
    logic [31:0] instr_exp, data_exp, stdout_exp;
    logic [31:0] mask_m, cnt_m;
    logic        irq_m;
    int          value_errs = 0;
    int          proto_errs = 0;

    assign value_errs_o = value_errs;
    assign proto_errs_o = proto_errs;

    function automatic logic in_range(input logic [31:0] a, input logic [31:0] base,
                                      input logic [31:0] len);
        return (a >= base) && (a - base < len);
    endfunction

    // RAM sits at SRAM_BASE and is mirrored at address 0
    function automatic logic ram_hit(input logic [31:0] a);
        return in_range(a, mm_map_pkg::SRAM_BASE, mm_map_pkg::SRAM_LEN) ||
               in_range(a, 32'h0, mm_map_pkg::SRAM_LEN);
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        logic [11:0] w;
        w = {a[11:2], 2'b00};
        return {ram_model[w + 3], ram_model[w + 2], ram_model[w + 1], ram_model[w]};
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_response(input string port, input logic pend, input logic rvalid,
                                  input logic [31:0] exp, input logic [31:0] act);
        if (rvalid !== pend) begin
            if (pend) $display("%0t: %s request granted last cycle got no rvalid", $time, port);
            else $display("%0t: %s rvalid came without a granted request", $time, port);
            proto_errs++;
        end else if (pend) begin
            compare({port, " rdata"}, exp, act);
        end
    endtask

    always @(posedge clk_i) begin : check_edge
        logic [31:0] ofs;
        logic        reg_wr;
        if (!rst_ni) begin
            instr_pend  = 1'b0;
            data_pend   = 1'b0;
            stdout_pend = 1'b0;
            mask_m      = '0;
            cnt_m       = '0;
            irq_m       = 1'b0;
        end else begin
            compare("instr_gnt_o", {31'b0, instr_req_i}, {31'b0, instr_gnt_i});
            compare("data_gnt_o", {31'b0, data_req_i}, {31'b0, data_gnt_i});
            compare("irq_id_o", 32'd3, {27'b0, dut_irq_id_i});
            compare("irq_o", {31'b0, irq_m}, {31'b0, dut_irq_i});
            check_response("fetch", instr_pend, instr_rvalid_i, instr_exp, instr_rdata_i);
            check_response("data", data_pend, data_rvalid_i, data_exp, data_rdata_i);
            if (stdout_valid_i !== stdout_pend) begin
                $display("%0t: stdout_valid_o is %b, a stdout write last cycle was %b",
                         $time, stdout_valid_i, stdout_pend);
                proto_errs++;
            end else if (stdout_pend) begin
                compare("stdout_data_o", stdout_exp, stdout_data_i);
            end

            // responses for this edge read the RAM before this edge's write lands
            instr_pend  = instr_req_i;
            instr_exp   = (instr_req_i && ram_hit(instr_addr_i)) ? model_word(instr_addr_i) : '0;
            data_pend   = data_req_i;
            data_exp    = (data_req_i && !data_we_i && ram_hit(data_addr_i))
                          ? model_word(data_addr_i) : '0;
            stdout_pend = data_req_i && data_we_i &&
                          in_range(data_addr_i, mm_map_pkg::STDOUT_BASE, mm_map_pkg::STDOUT_LEN);
            stdout_exp  = data_wdata_i;
            if (data_req_i && data_we_i && ram_hit(data_addr_i)) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_be_i[b]) begin
                        ram_model[{data_addr_i[11:2], 2'b00} + b] = data_wdata_i[8*b +: 8];
                    end
                end
            end

            // only the mask and count offsets of the timer are register writes
            ofs    = data_addr_i - mm_map_pkg::TIMER_BASE;
            reg_wr = data_req_i && data_we_i &&
                     in_range(data_addr_i, mm_map_pkg::TIMER_BASE, mm_map_pkg::TIMER_LEN) &&
                     (ofs == mm_map_pkg::TIMER_MASK_OFS || ofs == mm_map_pkg::TIMER_CNT_OFS);
            if (reg_wr) begin
                if (ofs == mm_map_pkg::TIMER_CNT_OFS) cnt_m = data_wdata_i;
                else mask_m = data_wdata_i;
            end else begin
                if (cnt_m == 32'd1 && mask_m[3]) irq_m = 1'b1;
                if (cnt_m != 32'd0) cnt_m = cnt_m - 32'd1;
                if (irq_ack_i && irq_id_i == 5'd3) irq_m = 1'b0;
            end
        end
    end

endmodule

/* tb_mm_ram.sv */
/*
 * Testbench top for the memory-mapped RAM wrapper.
 * Fills the RAM, runs seeded random fetch and data traffic, then a
 * directed timer interrupt sequence. tb_mm_checker does the comparing.
 */

`timescale 1ns/1ps

module tb_mm_ram;

    localparam int FILL_WORDS   = 1024;
    localparam int NUM_RANDOM   = 3000;
    localparam int TIMER_CYCLES = 300;
    localparam int CYCLE_LIMIT  = 2 * (10 + FILL_WORDS + NUM_RANDOM + TIMER_CYCLES + 20);

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        instr_req, instr_gnt, instr_rvalid;
    logic [31:0] instr_addr, instr_rdata;
    logic        data_req, data_we, data_gnt, data_rvalid;
    logic [3:0]  data_be;
    logic [31:0] data_addr, data_wdata, data_rdata;
    logic        stdout_valid;
    logic [31:0] stdout_data;
    logic        irq_ack, irq;
    logic [4:0]  irq_id, irq_id_out;
    int          value_errs, proto_errs;
    int          seq_errs = 0;
    int          cycle_cnt = 0;

    always #5 clk_i = ~clk_i;

    mm_ram i_dut (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .instr_req_i (instr_req), .instr_addr_i (instr_addr), .instr_gnt_o (instr_gnt),
        .instr_rvalid_o (instr_rvalid), .instr_rdata_o (instr_rdata),
        .data_req_i (data_req), .data_addr_i (data_addr), .data_we_i (data_we),
        .data_be_i (data_be), .data_wdata_i (data_wdata), .data_gnt_o (data_gnt),
        .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata),
        .stdout_valid_o (stdout_valid), .stdout_data_o (stdout_data),
        .irq_ack_i (irq_ack), .irq_id_i (irq_id), .irq_o (irq), .irq_id_o (irq_id_out)
    );

    tb_mm_checker i_checker (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .instr_req_i (instr_req), .instr_addr_i (instr_addr), .instr_gnt_i (instr_gnt),
        .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata),
        .data_req_i (data_req), .data_addr_i (data_addr), .data_we_i (data_we),
        .data_be_i (data_be), .data_wdata_i (data_wdata), .data_gnt_i (data_gnt),
        .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata),
        .stdout_valid_i (stdout_valid), .stdout_data_i (stdout_data),
        .irq_ack_i (irq_ack), .irq_id_i (irq_id), .dut_irq_i (irq),
        .dut_irq_id_i (irq_id_out), .value_errs_o (value_errs), .proto_errs_o (proto_errs)
    );

    task automatic set_idle();
        instr_req  = 1'b0;
        instr_addr = '0;
        data_req   = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_be    = '0;
        data_wdata = '0;
        irq_ack    = 1'b0;
        irq_id     = '0;
    endtask

    task automatic data_cycle(input logic we, input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata);
        @(negedge clk_i);
        set_idle();
        data_req   = 1'b1;
        data_we    = we;
        data_addr  = addr;
        data_be    = be;
        data_wdata = wdata;
    endtask

    // 0 and 1 are the two RAM mirrors, then stdout, timer, unmapped
    function automatic int unsigned pick_kind();
        int unsigned r;
        r = $urandom_range(9, 0);
        return (r < 3) ? 0 : (r < 6) ? 1 : r - 4;
    endfunction

    function automatic logic [31:0] random_addr(input int unsigned kind);
        logic [31:0] ofs;
        ofs = $urandom & 32'h0000_0FFC;
        case (kind)
            0: return ofs;
            1: return mm_map_pkg::SRAM_BASE + ofs;
            2: return mm_map_pkg::STDOUT_BASE + ofs;
            3: return mm_map_pkg::TIMER_BASE + (ofs & 32'hC);
            default: return 32'h2000_0000 | ($urandom & 32'h0FFF_FFFC);
        endcase
    endfunction

    task automatic random_traffic();
        repeat (NUM_RANDOM) begin
            @(negedge clk_i);
            set_idle();
            instr_req  = ($urandom_range(9, 0) < 7);
            instr_addr = random_addr(pick_kind());
            data_req   = ($urandom_range(9, 0) < 8);
            data_we    = $urandom_range(1, 0);
            data_addr  = random_addr(pick_kind());
            data_be    = $urandom_range(15, 0);
            data_wdata = $urandom;
        end
    endtask

    task automatic timer_run(input logic [31:0] mask, input int unsigned count,
                             input logic expect_irq);
        int unsigned waited;
        data_cycle(1'b1, mm_map_pkg::TIMER_BASE + mm_map_pkg::TIMER_MASK_OFS, 4'hF, mask);
        data_cycle(1'b1, mm_map_pkg::TIMER_BASE + mm_map_pkg::TIMER_CNT_OFS, 4'hF, count);
        @(negedge clk_i);
        set_idle();
        waited = 0;
        while (!irq && waited < count + 10) begin
            @(negedge clk_i);
            waited++;
        end
        if (expect_irq && !irq) begin
            $display("%0t: timer interrupt never rose after loading count %0d", $time, count);
            seq_errs++;
        end else if (expect_irq) begin
            irq_ack = 1'b1;
            irq_id  = 5'd3;
            @(negedge clk_i);
            set_idle();
        end
        repeat (3) @(negedge clk_i);
    endtask

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(79));
        rst_ni = 1'b0;
        set_idle();
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        for (int w = 0; w < FILL_WORDS; w++) begin
            data_cycle(1'b1, 32'(w * 4), 4'hF, $urandom);
        end
        random_traffic();
        // park the timer and drop any interrupt left by random traffic
        data_cycle(1'b1, mm_map_pkg::TIMER_BASE + mm_map_pkg::TIMER_MASK_OFS, 4'hF, '0);
        data_cycle(1'b1, mm_map_pkg::TIMER_BASE + mm_map_pkg::TIMER_CNT_OFS, 4'hF, '0);
        @(negedge clk_i);
        set_idle();
        irq_ack = 1'b1;
        irq_id  = 5'd3;
        repeat (3) timer_run($urandom | 32'h8, $urandom_range(40, 2), 1'b1);
        timer_run($urandom & ~32'h8, $urandom_range(40, 2), 1'b0);
        repeat (5) @(negedge clk_i);
        $display("errors: %0d value, %0d protocol, %0d sequence",
                 value_errs, proto_errs, seq_errs);
        if (value_errs + proto_errs + seq_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
mm_bus_pkg.sv
mm_map_pkg.sv
mm_ram_if.sv
mm_dp_ram.sv
mm_timer.sv
mm_bus_decode.sv
mm_ram.sv
tb_mm_checker.sv
tb_mm_ram.sv

/* run_sim.sh */
#!/bin/sh
# build the RAM wrapper testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_mm_ram -f verilog.f -o tb_mm_ram
./obj_dir/tb_mm_ram > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
